//--- verilog/vseq_macros.svh
// Sizing constants of the vector instruction sequencer
// Included by the package and by any block that needs a raw depth value

`ifndef VSEQ_MACROS_SVH
`define VSEQ_MACROS_SVH

//////////////////////////////////////////////////
// Instruction and register space
//////////////////////////////////////////////////

// Number of instruction IDs in flight at most
`define VSEQ_NR_VINSN 8

// Architectural vector registers
`define VSEQ_NR_VREGS 32

//////////////////////////////////////////////////
// Per-unit instruction queues
//////////////////////////////////////////////////

// Arithmetic units can buffer two instructions
`define VSEQ_ALU_DEPTH  2
`define VSEQ_MFPU_DEPTH 2

// Memory units take one instruction at a time
`define VSEQ_LDU_DEPTH 1
`define VSEQ_STU_DEPTH 1

// Counter width, wide enough to hold the largest depth
`define VSEQ_CNT_W 2

`endif

//--- verilog/vseq_pkg.sv
// Types shared by all sequencer blocks and by the testbench
// Import with vseq_pkg::* inside the module body

`default_nettype none

`include "vseq_macros.svh"

package vseq_pkg;

  // Sizes derived from the macros
  localparam int unsigned NR_VINSN = `VSEQ_NR_VINSN;
  localparam int unsigned NR_VREGS = `VSEQ_NR_VREGS;
  localparam int unsigned NR_UNITS = 4;

  // Vector typedefs
  typedef logic [$clog2(NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(NR_VREGS)-1:0] vreg_t;
  typedef logic [NR_VINSN-1:0]         vid_mask_t;
  typedef logic [7:0]                  vl_t;
  typedef logic [`VSEQ_CNT_W-1:0]      cnt_t;
  typedef logic [NR_UNITS-1:0]         unit_vec_t;

  // One running or done mask per unit, and one hazard row per ID
  typedef vid_mask_t [NR_UNITS-1:0] unit_vid_mask_t;
  typedef vid_mask_t [NR_VINSN-1:0] hazard_table_t;

  // Mask register of masked instructions
  localparam vreg_t VMASK_REG = '0;

  // Execution units, values also index the per-unit vectors
  typedef enum logic [1:0] {
    UNIT_ALU  = 2'd0,
    UNIT_MFPU = 2'd1,
    UNIT_LDU  = 2'd2,
    UNIT_STU  = 2'd3
  } unit_e;

  typedef enum logic [2:0] {
    OP_VADD, OP_VSUB, OP_VAND, OP_VMUL, OP_VFADD, OP_VLE, OP_VSE
  } op_e;

  typedef enum logic {
    ISSUE_IDLE,
    ISSUE_HOLD
  } issue_state_e;

  // Decoded instruction from the dispatcher
  typedef struct packed {
    op_e   op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
    logic  vm;    // 1 means unmasked
    vl_t   vl;
  } seq_req_t;

  // One dependency mask per operand
  typedef struct packed {
    vid_mask_t hazard_vs1;
    vid_mask_t hazard_vs2;
    vid_mask_t hazard_vm;
    vid_mask_t hazard_vd;
  } hazard_t;

  // Request forwarded to the units
  typedef struct packed {
    vid_t     id;
    unit_e    unit;
    seq_req_t req;
    hazard_t  hazard;
  } pe_req_t;

  // Unit that executes a given operation
  function automatic unit_e op_unit(op_e op);
    unit_e unit;
    case (op)
      OP_VADD, OP_VSUB, OP_VAND: unit = UNIT_ALU;
      OP_VMUL, OP_VFADD:         unit = UNIT_MFPU;
      OP_VLE:                    unit = UNIT_LDU;
      OP_VSE:                    unit = UNIT_STU;
      default:                   unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

`default_nettype wire

//--- verilog/vseq_id_alloc.sv
// Tracks which IDs run in which unit and hands out the lowest free ID
// Also flags a full ID space and an idle sequencer

`timescale 1ns/10ps
`default_nettype none

module vseq_id_alloc (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // Issue strobe from the issue block
  input  wire logic                     issue_i,
  input  wire vseq_pkg::vid_t           issue_id_i,
  input  wire vseq_pkg::unit_e          issue_unit_i,
  // Completion pulses, one mask per unit
  input  wire vseq_pkg::unit_vid_mask_t pe_done_i,
  // Status
  output vseq_pkg::vid_mask_t           running_o,
  output vseq_pkg::vid_t                free_id_o,
  output logic                          id_full_o,
  output logic                          idle_o
);

  import vseq_pkg::*;

  // Bit set while the ID runs in that unit
  unit_vid_mask_t unit_run_d, unit_run_q;

  always_comb begin : p_run_next
    // Retire finished IDs
    for (int u = 0; u < NR_UNITS; u++) begin
      unit_run_d[u] = unit_run_q[u] & ~pe_done_i[u];
    end
    // Mark the new ID in its target unit
    if (issue_i) begin
      unit_run_d[issue_unit_i][issue_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_run_ff
    if (!rst_ni) begin
      unit_run_q <= '0;
    end else begin
      unit_run_q <= unit_run_d;
    end
  end

  // Running anywhere
  always_comb begin : p_running
    running_o = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      running_o |= unit_run_q[u];
    end
  end

  // Lowest ID not running, scanned from the top so the lowest wins
  always_comb begin : p_free_id
    free_id_o = '0;
    for (int i = NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) free_id_o = vid_t'(i);
    end
  end

  assign id_full_o = &running_o;
  assign idle_o    = ~|running_o;

endmodule

`default_nettype wire

//--- verilog/vseq_reg_tracker.sv
// Keeps the last reader and writer ID of every vector register
// Computes the RAW, WAR and WAW hazard vectors of the pending request

`timescale 1ns/10ps
`default_nettype none

module vseq_reg_tracker (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // Pending request, stable while valid
  input  wire vseq_pkg::seq_req_t  seq_req_i,
  // Issue strobe and the ID given to the request
  input  wire logic                issue_i,
  input  wire vseq_pkg::vid_t      issue_id_i,
  // IDs currently running
  input  wire vseq_pkg::vid_mask_t running_i,
  // Dependencies of the pending request
  output vseq_pkg::hazard_t        hazard_o
);

  import vseq_pkg::*;

  // Access record of one register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_access_t;

  vreg_access_t [NR_VREGS-1:0] rd_list_d, rd_list_q;
  vreg_access_t [NR_VREGS-1:0] wr_list_d, wr_list_q;

  // Per-rule dependency masks
  vid_mask_t raw_vs1;
  vid_mask_t raw_vs2;
  vid_mask_t raw_vm;
  vid_mask_t war_vd;
  vid_mask_t waw_vd;

  // One-hot mask of a record whose ID still runs
  function automatic vid_mask_t access_mask(vreg_access_t acc, vid_mask_t running);
    vid_mask_t mask;
    mask          = '0;
    mask[acc.vid] = acc.valid & running[acc.vid];
    return mask;
  endfunction

  //////////////////////////////////////////////////
  // Hazard vectors
  //////////////////////////////////////////////////

  // Read after write on the sources
  assign raw_vs1 = seq_req_i.use_vs1 ? access_mask(wr_list_q[seq_req_i.vs1], running_i) : '0;
  assign raw_vs2 = seq_req_i.use_vs2 ? access_mask(wr_list_q[seq_req_i.vs2], running_i) : '0;

  // Masked requests read v0
  assign raw_vm = !seq_req_i.vm ? access_mask(wr_list_q[VMASK_REG], running_i) : '0;

  // Write after read and write after write on the destination
  assign war_vd = seq_req_i.use_vd ? access_mask(rd_list_q[seq_req_i.vd], running_i) : '0;
  assign waw_vd = seq_req_i.use_vd ? access_mask(wr_list_q[seq_req_i.vd], running_i) : '0;

  // WAR stalls every operand fetch of the new instruction
  assign hazard_o = '{
    hazard_vs1: raw_vs1 | war_vd,
    hazard_vs2: raw_vs2 | war_vd,
    hazard_vm : raw_vm  | war_vd,
    hazard_vd : waw_vd
  };

  //////////////////////////////////////////////////
  // Access lists
  //////////////////////////////////////////////////

  always_comb begin : p_lists_next
    rd_list_d = rd_list_q;
    wr_list_d = wr_list_q;

    // Drop records of IDs that finished
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_list_d[v].valid = rd_list_q[v].valid & running_i[rd_list_q[v].vid];
      wr_list_d[v].valid = wr_list_q[v].valid & running_i[wr_list_q[v].vid];
    end

    // Record the new instruction
    if (issue_i) begin
      if (seq_req_i.use_vd) wr_list_d[seq_req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      if (seq_req_i.use_vs1) rd_list_d[seq_req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      if (seq_req_i.use_vs2) rd_list_d[seq_req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      if (!seq_req_i.vm) rd_list_d[VMASK_REG] = '{vid: issue_id_i, valid: 1'b1};
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lists_ff
    if (!rst_ni) begin
      rd_list_q <= '0;
      wr_list_q <= '0;
    end else begin
      rd_list_q <= rd_list_d;
      wr_list_q <= wr_list_d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vseq_unit_credits.sv
// Counts the instructions queued in each unit
// Grants issue only while the target unit has a free queue slot

`timescale 1ns/10ps
`default_nettype none

`include "vseq_macros.svh"

module vseq_unit_credits (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // Issue strobe and its target unit
  input  wire logic                     issue_i,
  input  wire vseq_pkg::unit_e          issue_unit_i,
  // Completion pulses, one mask per unit
  input  wire vseq_pkg::unit_vid_mask_t pe_done_i,
  // Unit of the pending request
  input  wire vseq_pkg::unit_e          req_unit_i,
  output logic                          unit_ok_o
);

  import vseq_pkg::*;

  // Queue depth per unit, ALU in the lowest slot
  localparam cnt_t [NR_UNITS-1:0] UNIT_DEPTH = {
    cnt_t'(`VSEQ_STU_DEPTH),
    cnt_t'(`VSEQ_LDU_DEPTH),
    cnt_t'(`VSEQ_MFPU_DEPTH),
    cnt_t'(`VSEQ_ALU_DEPTH)
  };

  cnt_t [NR_UNITS-1:0] cnt_q;
  unit_vec_t           cnt_up;
  unit_vec_t           cnt_down;

  // Up on issue, down on any completion of that unit
  always_comb begin : p_cnt_ctrl
    for (int u = 0; u < NR_UNITS; u++) begin
      cnt_up[u]   = issue_i & (issue_unit_i == unit_e'(u));
      cnt_down[u] = |pe_done_i[u];
    end
  end

  // Holds when an issue and a completion meet
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_cnt_ff
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int u = 0; u < NR_UNITS; u++) begin
        if (cnt_up[u] && !cnt_down[u]) begin
          cnt_q[u] <= cnt_q[u] + cnt_t'(1);
        end else if (cnt_down[u] && !cnt_up[u]) begin
          cnt_q[u] <= cnt_q[u] - cnt_t'(1);
        end
      end
    end
  end

  // Free slot in the requested unit
  assign unit_ok_o = cnt_q[req_unit_i] < UNIT_DEPTH[req_unit_i];

endmodule

`default_nettype wire

//--- verilog/vseq_issue.sv
// Accepts dispatcher requests and forwards them to the units
// Holds the output request under back-pressure and owns the global hazard table

`timescale 1ns/10ps
`default_nettype none

module vseq_issue (
  input  wire logic                    clk_i,
  input  wire logic                    rst_ni,
  // Dispatcher handshake
  input  wire vseq_pkg::seq_req_t      seq_req_i,
  input  wire logic                    seq_req_valid_i,
  output logic                         seq_req_ready_o,
  // Status from the other blocks
  input  wire vseq_pkg::vid_t          free_id_i,
  input  wire logic                    id_full_i,
  input  wire logic                    unit_ok_i,
  input  wire vseq_pkg::hazard_t       hazard_i,
  input  wire vseq_pkg::vid_mask_t     running_i,
  // Unit handshake
  input  wire vseq_pkg::unit_vec_t     pe_req_ready_i,
  // Issue strobe to the other blocks
  output logic                         issue_o,
  output vseq_pkg::vid_t               issue_id_o,
  output vseq_pkg::unit_e              issue_unit_o,
  // Request to the units
  output vseq_pkg::pe_req_t            pe_req_o,
  output logic                         pe_req_valid_o,
  // Dependencies for the operand requesters
  output vseq_pkg::hazard_table_t      global_hazard_table_o
);

  import vseq_pkg::*;

  issue_state_e  state_d, state_q;
  pe_req_t       pe_req_d;
  logic          pe_req_valid_d;
  logic          consume;
  logic          stall;
  hazard_table_t table_d, table_q;

  //////////////////////////////////////////////////
  // Handshakes
  //////////////////////////////////////////////////

  // Target unit takes the pending request
  assign consume = pe_req_valid_o & pe_req_ready_i[pe_req_o.unit];
  // Pending request refused this cycle
  assign stall   = pe_req_valid_o & ~consume;

  // Unit and ID of the request at the input
  assign issue_unit_o = op_unit(seq_req_i.op);
  assign issue_id_o   = free_id_i;

  // Never overwrite a request that is still waiting
  assign seq_req_ready_o = (state_q == ISSUE_IDLE) & ~stall & ~id_full_i & unit_ok_i;
  assign issue_o         = seq_req_valid_i & seq_req_ready_o;

  // HOLD while the target unit back-pressures
  always_comb begin : p_fsm
    state_d = state_q;
    case (state_q)
      ISSUE_IDLE: if (stall) state_d = ISSUE_HOLD;
      ISSUE_HOLD: if (consume) state_d = ISSUE_IDLE;
      default:    state_d = ISSUE_IDLE;
    endcase
  end

  //////////////////////////////////////////////////
  // Output request
  //////////////////////////////////////////////////

  assign pe_req_d = '{
    id    : free_id_i,
    unit  : issue_unit_o,
    req   : seq_req_i,
    hazard: hazard_i
  };

  // Valid clears on consumption, a new issue sets it again
  assign pe_req_valid_d = issue_o | (pe_req_valid_o & ~consume);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl_ff
    if (!rst_ni) begin
      state_q        <= ISSUE_IDLE;
      pe_req_valid_o <= 1'b0;
      table_q        <= '0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
      table_q        <= table_d;
    end
  end

  always_ff @(posedge clk_i) begin : p_req_ff
    if (issue_o) pe_req_o <= pe_req_d;
  end

  //////////////////////////////////////////////////
  // Global hazard table
  //////////////////////////////////////////////////

  // Row N lists the running IDs that instruction N waits for
  always_comb begin : p_table_next
    for (int i = 0; i < NR_VINSN; i++) begin
      table_d[i] = table_q[i] & running_i;
    end
    if (issue_o) begin
      table_d[free_id_i] = hazard_i.hazard_vs1 | hazard_i.hazard_vs2 |
                           hazard_i.hazard_vm  | hazard_i.hazard_vd;
    end
  end

  // Finished IDs drop out of every row right away
  always_comb begin : p_table_out
    for (int i = 0; i < NR_VINSN; i++) begin
      global_hazard_table_o[i] = table_q[i] & running_i;
    end
  end

endmodule

`default_nettype wire

//--- verilog/vseq_top.sv
// Vector instruction sequencer top level
// Connects ID allocation, register tracking, unit credits and issue control

`timescale 1ns/10ps
`default_nettype none

module vseq_top (
  input  wire logic                     clk_i,
  input  wire logic                     rst_ni,
  // Dispatcher side
  input  wire vseq_pkg::seq_req_t       seq_req_i,
  input  wire logic                     seq_req_valid_i,
  output logic                          seq_req_ready_o,
  // Unit side
  output vseq_pkg::pe_req_t             pe_req_o,
  output logic                          pe_req_valid_o,
  input  wire vseq_pkg::unit_vec_t      pe_req_ready_i,
  input  wire vseq_pkg::unit_vid_mask_t pe_done_i,
  // Operand requesters and status
  output vseq_pkg::hazard_table_t       global_hazard_table_o,
  output logic                          idle_o
);

  import vseq_pkg::*;

  // Status towards the issue block
  vid_mask_t running;
  vid_t      free_id;
  logic      id_full;
  logic      unit_ok;
  hazard_t   hazard;

  // Issue strobe towards the bookkeeping blocks
  logic      issue;
  vid_t      issue_id;
  unit_e     issue_unit;

  vseq_id_alloc u_id_alloc (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_id_i   (issue_id),
    .issue_unit_i (issue_unit),
    .pe_done_i    (pe_done_i),
    .running_o    (running),
    .free_id_o    (free_id),
    .id_full_o    (id_full),
    .idle_o       (idle_o)
  );

  vseq_reg_tracker u_reg_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .seq_req_i  (seq_req_i),
    .issue_i    (issue),
    .issue_id_i (issue_id),
    .running_i  (running),
    .hazard_o   (hazard)
  );

  // Requested unit is the one the issue block decodes
  vseq_unit_credits u_unit_credits (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_unit_i (issue_unit),
    .pe_done_i    (pe_done_i),
    .req_unit_i   (issue_unit),
    .unit_ok_o    (unit_ok)
  );

  vseq_issue u_issue (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .seq_req_i             (seq_req_i),
    .seq_req_valid_i       (seq_req_valid_i),
    .seq_req_ready_o       (seq_req_ready_o),
    .free_id_i             (free_id),
    .id_full_i             (id_full),
    .unit_ok_i             (unit_ok),
    .hazard_i              (hazard),
    .running_i             (running),
    .pe_req_ready_i        (pe_req_ready_i),
    .issue_o               (issue),
    .issue_id_o            (issue_id),
    .issue_unit_o          (issue_unit),
    .pe_req_o              (pe_req_o),
    .pe_req_valid_o        (pe_req_valid_o),
    .global_hazard_table_o (global_hazard_table_o)
  );

endmodule

`default_nettype wire

//--- verification/vseq_assert.sv
// Concurrent checks on the sequencer top level
// Attached to every vseq_top instance by the bind at the end of this file

`timescale 1ns/10ps
`default_nettype none

module vseq_assert (
  input wire logic                     clk_i,
  input wire logic                     rst_ni,
  input wire logic                     seq_req_valid_i,
  input wire logic                     seq_req_ready_i,
  input wire vseq_pkg::pe_req_t        pe_req_i,
  input wire logic                     pe_req_valid_i,
  input wire vseq_pkg::unit_vec_t      pe_req_ready_i,
  input wire vseq_pkg::unit_vid_mask_t pe_done_i
);

  import vseq_pkg::*;

  // Every ID the pending request waits for
  vid_mask_t hazard_all;

  // IDs in use, rebuilt from the handshakes and the done pulses
  logic      accepted_q;
  vid_mask_t new_id;
  vid_mask_t done_any;
  vid_mask_t in_use;
  vid_mask_t in_use_q;

  assign hazard_all = pe_req_i.hazard.hazard_vs1 | pe_req_i.hazard.hazard_vs2 |
                      pe_req_i.hazard.hazard_vm  | pe_req_i.hazard.hazard_vd;

  // Request register shows the new ID one cycle after acceptance
  always_comb begin : p_in_use
    new_id   = '0;
    done_any = '0;
    if (accepted_q) new_id[pe_req_i.id] = 1'b1;
    for (int u = 0; u < NR_UNITS; u++) begin
      done_any |= pe_done_i[u];
    end
  end

  assign in_use = in_use_q | new_id;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_in_use_ff
    if (!rst_ni) begin
      accepted_q <= 1'b0;
      in_use_q   <= '0;
    end else begin
      accepted_q <= seq_req_valid_i & seq_req_ready_i;
      in_use_q   <= in_use & ~done_any;
    end
  end

  // Refused request is held unchanged
  a_hold_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i && !pe_req_ready_i[pe_req_i.unit] |=> pe_req_valid_i && $stable(pe_req_i)
  ) else $error("pe_req changed while the target unit refused it");

  // No instruction depends on itself
  a_no_self_hazard : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i |-> !hazard_all[pe_req_i.id]
  ) else $error("request lists its own ID as a hazard");

  // All IDs in use, nothing is accepted
  a_full_not_ready : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    &in_use |-> !seq_req_ready_i
  ) else $error("ready raised with every ID running");

endmodule

bind vseq_top vseq_assert u_assert (
  .clk_i           (clk_i),
  .rst_ni          (rst_ni),
  .seq_req_valid_i (seq_req_valid_i),
  .seq_req_ready_i (seq_req_ready_o),
  .pe_req_i        (pe_req_o),
  .pe_req_valid_i  (pe_req_valid_o),
  .pe_req_ready_i  (pe_req_ready_i),
  .pe_done_i       (pe_done_i)
);

`default_nettype wire

//--- verification/vseq_tb.sv
// Testbench of the vector instruction sequencer
// Models the dispatcher and four units, checks every forwarded request against a model

`timescale 1ns/10ps
`default_nettype none

`include "vseq_macros.svh"

module vseq_tb;

  import vseq_pkg::*;

  localparam int NR_REQS        = 160;
  localparam int TIMEOUT_CYCLES = 200;

  // DUT signals
  logic           clk_i;
  logic           rst_ni;
  seq_req_t       seq_req_i;
  logic           seq_req_valid_i;
  logic           seq_req_ready_o;
  pe_req_t        pe_req_o;
  logic           pe_req_valid_o;
  unit_vec_t      pe_req_ready_i;
  unit_vid_mask_t pe_done_i;
  hazard_table_t  global_hazard_table_o;
  logic           idle_o;

  // Random source
  logic [15:0] lfsr_q;

  // Reference model state
  vid_mask_t model_running;
  vid_mask_t model_unit_run [NR_UNITS];
  vid_mask_t model_row [NR_VINSN];
  vid_t      rd_id [NR_VREGS];
  logic      rd_valid [NR_VREGS];
  vid_t      wr_id [NR_VREGS];
  logic      wr_valid [NR_VREGS];

  // Accepted requests not yet consumed, and IDs queued in each unit
  pe_req_t   pending_q [$];
  vid_t      unit_fifo [NR_UNITS][$];
  int        retire_wait [NR_UNITS];
  int        accept_cnt;
  logic      valid_due;

  vseq_top dut_i (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .seq_req_i             (seq_req_i),
    .seq_req_valid_i       (seq_req_valid_i),
    .seq_req_ready_o       (seq_req_ready_o),
    .pe_req_o              (pe_req_o),
    .pe_req_valid_o        (pe_req_valid_o),
    .pe_req_ready_i        (pe_req_ready_i),
    .pe_done_i             (pe_done_i),
    .global_hazard_table_o (global_hazard_table_o),
    .idle_o                (idle_o)
  );

  initial begin : p_clk
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Reporting
  //////////////////////////////////////////////////

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input logic [127:0] actual, input logic [127:0] expected,
                             input string what);
    if (actual !== expected) begin
      stop_with_failure($sformatf("Fail at %0d ns: %s, got %0h, expected %0h",
                                  $time, what, actual, expected));
    end
  endtask

  //////////////////////////////////////////////////
  // Random bits
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic take_bits(input int n, output logic [15:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits   = {bits[14:0], lfsr_q[15]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  function automatic unit_e unit_of(op_e op);
    case (op)
      OP_VMUL, OP_VFADD: return UNIT_MFPU;
      OP_VLE:            return UNIT_LDU;
      OP_VSE:            return UNIT_STU;
      default:           return UNIT_ALU;
    endcase
  endfunction

  function automatic int queue_depth(int u);
    case (u)
      0:       return `VSEQ_ALU_DEPTH;
      1:       return `VSEQ_MFPU_DEPTH;
      2:       return `VSEQ_LDU_DEPTH;
      default: return `VSEQ_STU_DEPTH;
    endcase
  endfunction

  // One-hot of a list entry, only while its owner still runs
  function automatic vid_mask_t live_mask(logic valid, vid_t id);
    vid_mask_t m;
    m = '0;
    if (valid && model_running[id]) m[id] = 1'b1;
    return m;
  endfunction

  // Expected ID, unit and hazards of a request accepted now
  function automatic pe_req_t expected_pe_req(seq_req_t req);
    pe_req_t   want;
    vid_mask_t war;
    vid_mask_t raw1;
    vid_mask_t raw2;
    vid_mask_t rawm;
    logic      found;
    want  = '0;
    found = 1'b0;
    for (int i = 0; i < NR_VINSN; i++) begin
      if (!found && !model_running[i]) begin
        want.id = vid_t'(i);
        found   = 1'b1;
      end
    end
    want.unit = unit_of(req.op);
    want.req  = req;
    raw1 = req.use_vs1 ? live_mask(wr_valid[req.vs1], wr_id[req.vs1]) : '0;
    raw2 = req.use_vs2 ? live_mask(wr_valid[req.vs2], wr_id[req.vs2]) : '0;
    // Masked requests read v0
    rawm = !req.vm ? live_mask(wr_valid[0], wr_id[0]) : '0;
    war  = req.use_vd ? live_mask(rd_valid[req.vd], rd_id[req.vd]) : '0;
    want.hazard.hazard_vs1 = raw1 | war;
    want.hazard.hazard_vs2 = raw2 | war;
    want.hazard.hazard_vm  = rawm | war;
    want.hazard.hazard_vd  = req.use_vd ? live_mask(wr_valid[req.vd], wr_id[req.vd]) : '0;
    return want;
  endfunction

  // One clock edge of the model, finished IDs leave one cycle after done
  task automatic advance_model(input logic accept, input seq_req_t req, input pe_req_t want);
    vid_mask_t run_now;
    run_now = model_running;
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_valid[v] = rd_valid[v] & run_now[rd_id[v]];
      wr_valid[v] = wr_valid[v] & run_now[wr_id[v]];
    end
    for (int i = 0; i < NR_VINSN; i++) begin
      model_row[i] = model_row[i] & run_now;
    end
    for (int u = 0; u < NR_UNITS; u++) begin
      model_unit_run[u] = model_unit_run[u] & ~pe_done_i[u];
    end
    if (accept) begin
      if (req.use_vd) begin
        wr_id[req.vd]    = want.id;
        wr_valid[req.vd] = 1'b1;
      end
      if (req.use_vs1) begin
        rd_id[req.vs1]    = want.id;
        rd_valid[req.vs1] = 1'b1;
      end
      if (req.use_vs2) begin
        rd_id[req.vs2]    = want.id;
        rd_valid[req.vs2] = 1'b1;
      end
      if (!req.vm) begin
        rd_id[0]    = want.id;
        rd_valid[0] = 1'b1;
      end
      model_row[want.id] = want.hazard.hazard_vs1 | want.hazard.hazard_vs2 |
                           want.hazard.hazard_vm  | want.hazard.hazard_vd;
      model_unit_run[want.unit][want.id] = 1'b1;
    end
    model_running = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      model_running = model_running | model_unit_run[u];
    end
  endtask

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin : p_compare
    pe_req_t want;
    pe_req_t head;
    logic    accept;
    logic    consume;
    if (rst_ni) begin
      want    = '0;
      accept  = seq_req_valid_i & seq_req_ready_o;
      consume = pe_req_valid_o & pe_req_ready_i[pe_req_o.unit];
      check_equal(128'(idle_o), 128'(model_running == '0), "idle flag");
      if (valid_due) begin
        check_equal(128'(pe_req_valid_o), 128'(1), "request valid one cycle after acceptance");
      end
      // Back-pressure blocks new requests
      if (pe_req_valid_o && !consume) begin
        check_equal(128'(accept), 128'(0), "request accepted under back-pressure");
      end
      if (consume) begin
        check_equal(128'(pending_q.size()), 128'(1), "requests waiting for consumption");
        head = pending_q.pop_front();
        check_equal(128'(pe_req_o.id), 128'(head.id), "instruction ID");
        check_equal(128'(pe_req_o.unit), 128'(head.unit), "target unit");
        check_equal(128'(pe_req_o.req), 128'(head.req), "instruction fields");
        check_equal(128'(pe_req_o.hazard), 128'(head.hazard), "hazard vectors");
        check_equal(128'(global_hazard_table_o[head.id]),
                    128'(model_row[head.id] & model_running), "hazard table row");
        unit_fifo[head.unit].push_back(head.id);
      end
      if (accept) begin
        want = expected_pe_req(seq_req_i);
        pending_q.push_back(want);
        accept_cnt++;
      end
      advance_model(accept, seq_req_i, want);
      valid_due = accept;
      for (int u = 0; u < NR_UNITS; u++) begin
        check_equal(128'($countones(model_unit_run[u]) > queue_depth(u)), 128'(0),
                    "IDs running in a unit above its queue depth");
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  // Units retire their oldest ID after a random delay, each with its own ready rate
  task automatic drive_units();
    unit_vid_mask_t done;
    logic [15:0]    bits;
    vid_t           id;
    done = '0;
    for (int u = 0; u < NR_UNITS; u++) begin
      if (unit_fifo[u].size() != 0) begin
        if (retire_wait[u] == 0) begin
          id          = unit_fifo[u].pop_front();
          done[u][id] = 1'b1;
          take_bits(3, bits);
          retire_wait[u] = int'(bits[2:0]);
        end else begin
          retire_wait[u]--;
        end
      end
    end
    pe_done_i = done;
    take_bits(4, bits);
    // STU mostly ready, LDU seldom
    pe_req_ready_i = {~(bits[0] & bits[2] & bits[3]), bits[1] & bits[3],
                      bits[2], bits[0] | bits[1]};
  endtask

  task automatic build_request(output seq_req_t req);
    logic [15:0] bits;
    take_bits(3, bits);
    req.op = (bits[2:0] == 3'd7) ? OP_VADD : op_e'(bits[2:0]);
    // Registers v0 to v7 only, so hazards are frequent
    take_bits(3, bits);
    req.vs1 = vreg_t'(bits[2:0]);
    take_bits(3, bits);
    req.vs2 = vreg_t'(bits[2:0]);
    take_bits(3, bits);
    req.vd = vreg_t'(bits[2:0]);
    take_bits(6, bits);
    req.use_vs1 = bits[0] | bits[1];
    req.use_vs2 = bits[2] | bits[3];
    req.use_vd  = bits[4] | bits[5];
    // One in four masked
    take_bits(2, bits);
    req.vm = |bits[1:0];
    take_bits(8, bits);
    req.vl = vl_t'(bits[7:0]);
  endtask

  task automatic wait_accept(input int target);
    int waited;
    waited = 0;
    while (accept_cnt != target) begin
      @(negedge clk_i);
      drive_units();
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("Timeout waiting for request %0d to be accepted", target));
      end
    end
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    do begin
      @(negedge clk_i);
      drive_units();
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        stop_with_failure("Timeout waiting for the sequencer to become idle");
      end
    end while (!idle_o || pe_req_valid_o);
    check_equal(128'(global_hazard_table_o), 128'(0), "hazard table when idle");
  endtask

  initial begin : p_main
    seq_req_t    req;
    logic [15:0] bits;
    lfsr_q          = 16'd99;
    rst_ni          = 1'b0;
    seq_req_i       = '0;
    seq_req_valid_i = 1'b0;
    pe_req_ready_i  = '0;
    pe_done_i       = '0;
    model_running   = '0;
    accept_cnt      = 0;
    valid_due       = 1'b0;
    for (int v = 0; v < NR_VREGS; v++) begin
      rd_id[v]    = '0;
      rd_valid[v] = 1'b0;
      wr_id[v]    = '0;
      wr_valid[v] = 1'b0;
    end
    for (int i = 0; i < NR_VINSN; i++) begin
      model_row[i] = '0;
    end
    for (int u = 0; u < NR_UNITS; u++) begin
      model_unit_run[u] = '0;
      retire_wait[u]    = 0;
    end
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_equal(128'(idle_o), 128'(1), "idle after reset");
    check_equal(128'(pe_req_valid_o), 128'(0), "request valid after reset");
    check_equal(128'(seq_req_ready_o), 128'(1), "ready after reset");

    for (int n = 0; n < NR_REQS; n++) begin
      build_request(req);
      seq_req_i       = req;
      seq_req_valid_i = 1'b1;
      wait_accept(n + 1);
      seq_req_valid_i = 1'b0;
      // Occasional empty cycle on the dispatcher side
      take_bits(2, bits);
      if (bits[1:0] == 2'b00) begin
        @(negedge clk_i);
        drive_units();
      end
      // Drain once halfway so the sequencer goes idle in the middle of the run
      if (n == NR_REQS / 2) wait_idle();
    end
    wait_idle();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim.f
+incdir+verilog
verilog/vseq_pkg.sv
verilog/vseq_id_alloc.sv
verilog/vseq_reg_tracker.sv
verilog/vseq_unit_credits.sv
verilog/vseq_issue.sv
verilog/vseq_top.sv
verification/vseq_assert.sv
verification/vseq_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the sequencer testbench with Verilator
# Exit status is nonzero when compilation or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module vseq_tb \
  --Mdir obj_dir -o vseq_sim \
  -f sim.f
if [ $? -ne 0 ]; then
  echo "Verilator compilation failed"
  exit 1
fi

./obj_dir/vseq_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit $status
fi

exit 0
